// File: include/runner_consts.svh
`ifndef RUNNER_CONSTS_SVH
`define RUNNER_CONSTS_SVH

// Display geometry
`define SCREEN_W        160
`define SCREEN_H        120
`define SPRITE_SIZE     10

// 3-bit colour codes
`define COL_BLACK       3'd0
`define COL_RED         3'd4
`define COL_YELLOW      3'd6
`define COL_WHITE       3'd7

// Sprite kinds
`define SPRITE_SQUARE   1'b0
`define SPRITE_SPIKE    1'b1

// Player idle position, bottom-left corner
`define PLAYER_X        59
`define PLAYER_Y        89

// Level and scrolling
`define NUM_OBSTACLES   10
`define WORLD_W         320     // Scroll offset wraps here
`define SCROLL_STEP     2

// Minimum cycles between frame starts
`define FRAME_CYCLES    24000

// Credits toward the frame buffer
`define CREDIT_MAX      4

`endif

// File: verilog/runner_pkg.sv
package runner_pkg;

    typedef logic [10:0] coord_t;   // Screen or world coordinate
    typedef logic [2:0]  colour_t;
    typedef logic        sprite_t;  // Square or spike
    typedef logic [3:0]  row_t;     // Sprite row or column index
    typedef logic [7:0]  span_t;    // Job width or height

    // One rectangle for the rasterizer, corner is bottom-left
    typedef struct packed {
        coord_t  x;
        coord_t  y;
        span_t   w;
        span_t   h;
        colour_t colour;
        sprite_t sprite;
        logic    use_mask;   // Apply sprite row limits
        logic    plain;      // Walk rows downward from y (screen fill)
    } raster_job_t;

    typedef struct packed {
        coord_t  x;
        coord_t  y;
        colour_t colour;
    } pixel_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_CLEAR,
        SEQ_PLAYER,
        SEQ_OBSTACLE,
        SEQ_DONE
    } seq_state_t;

endpackage

// File: verilog/sprite_rom.sv
`timescale 1ns/1ps
`include "runner_consts.svh"

module sprite_rom (
    input  runner_pkg::sprite_t sprite,
    input  runner_pkg::row_t    row,
    output runner_pkg::row_t    row_start,
    output runner_pkg::row_t    row_end
);

    // Row 0 is the bottom row of the sprite
    always_comb begin
        row_start = 4'd0;
        row_end   = 4'd9;
        if (sprite == `SPRITE_SPIKE) begin
            case (row)
                4'd0: {row_start, row_end} = {4'd0, 4'd9};  // Wide base
                4'd1: {row_start, row_end} = {4'd0, 4'd9};
                4'd2: {row_start, row_end} = {4'd1, 4'd8};
                4'd3: {row_start, row_end} = {4'd1, 4'd8};
                4'd4: {row_start, row_end} = {4'd2, 4'd7};
                4'd5: {row_start, row_end} = {4'd2, 4'd7};
                4'd6: {row_start, row_end} = {4'd3, 4'd6};
                4'd7: {row_start, row_end} = {4'd3, 4'd6};
                4'd8: {row_start, row_end} = {4'd4, 4'd5};
                4'd9: {row_start, row_end} = {4'd4, 4'd5};  // Tip
                default: begin
                    // Outside the sprite, keep the full row
                    row_start = 4'd0;
                    row_end   = 4'd9;
                end
            endcase
        end
    end

endmodule

// File: verilog/obstacle_table.sv
`timescale 1ns/1ps
`include "runner_consts.svh"

module obstacle_table (
    input  logic                clock_50,
    input  logic                rst,
    input  logic                advance_scroll,
    input  logic [3:0]          obs_index,
    output runner_pkg::coord_t  obs_x,
    output runner_pkg::coord_t  obs_y,
    output runner_pkg::sprite_t obs_sprite,
    output runner_pkg::colour_t obs_colour,
    output logic                obs_visible
);

    runner_pkg::coord_t offset;      // Scroll position in world columns
    runner_pkg::coord_t next_offset;
    runner_pkg::coord_t world_x;
    logic               in_table;

    // Level layout, world x and y level per obstacle
    always_comb begin
        in_table = 1'b1;
        world_x  = '0;
        obs_y    = '0;
        case (obs_index)
            4'd0:    {world_x, obs_y} = {11'd69,  11'd89};
            4'd1:    {world_x, obs_y} = {11'd99,  11'd59};
            4'd2:    {world_x, obs_y} = {11'd109, 11'd39};
            4'd3:    {world_x, obs_y} = {11'd119, 11'd59};
            4'd4:    {world_x, obs_y} = {11'd129, 11'd89};
            4'd5:    {world_x, obs_y} = {11'd139, 11'd89};
            4'd6:    {world_x, obs_y} = {11'd149, 11'd59};
            4'd7:    {world_x, obs_y} = {11'd159, 11'd39};
            4'd8:    {world_x, obs_y} = {11'd169, 11'd59};
            4'd9:    {world_x, obs_y} = {11'd179, 11'd89};
            default: in_table = 1'b0;
        endcase
    end

    // First half are blocks, second half spikes
    assign obs_sprite = (obs_index < 4'(`NUM_OBSTACLES / 2)) ? `SPRITE_SQUARE : `SPRITE_SPIKE;
    assign obs_colour = (obs_sprite == `SPRITE_SPIKE) ? `COL_WHITE : `COL_YELLOW;

    assign obs_x       = world_x - offset;
    assign obs_visible = in_table && (world_x >= offset) &&
                         (obs_x <= runner_pkg::coord_t'(`SCREEN_W - 1));

    assign next_offset = offset + runner_pkg::coord_t'(`SCROLL_STEP);

    always_ff @(posedge clock_50) begin
        if (rst) begin
            offset <= '0;
        end else if (advance_scroll) begin
            if (next_offset >= runner_pkg::coord_t'(`WORLD_W))
                offset <= next_offset - runner_pkg::coord_t'(`WORLD_W);  // Wrap the world
            else
                offset <= next_offset;
        end
    end

endmodule

// File: verilog/raster_engine.sv
`timescale 1ns/1ps
`include "runner_consts.svh"

module raster_engine (
    input  logic                    clock_50,
    input  logic                    rst,
    input  runner_pkg::raster_job_t job,
    input  logic                    job_valid,
    input  logic                    credit_return,
    input  runner_pkg::row_t        row_start,
    input  runner_pkg::row_t        row_end,
    output logic                    job_ready,
    output logic                    job_done,
    output runner_pkg::pixel_t      pix,
    output logic                    pix_valid,
    output runner_pkg::sprite_t     sprite,
    output runner_pkg::row_t        row
);

    runner_pkg::raster_job_t cur;    // Job being walked
    runner_pkg::span_t       col_cnt;
    runner_pkg::span_t       row_cnt;
    logic                    busy;
    logic [2:0]              credits;
    logic                    in_mask;
    logic                    in_screen;
    logic                    step;
    logic                    row_last;
    logic                    last;

    assign job_ready = !busy;
    assign sprite    = cur.sprite;
    assign row       = row_cnt[3:0];   // Sprite row from the bottom

    always_comb begin
        pix.x      = cur.x + runner_pkg::coord_t'(col_cnt);
        pix.y      = cur.plain ? cur.y + runner_pkg::coord_t'(row_cnt)
                               : cur.y - runner_pkg::coord_t'(row_cnt);
        pix.colour = cur.colour;
    end

    assign in_mask   = !cur.use_mask ||
                       ((col_cnt >= runner_pkg::span_t'(row_start)) &&
                        (col_cnt <= runner_pkg::span_t'(row_end)));
    assign in_screen = pix.x < runner_pkg::coord_t'(`SCREEN_W);  // Right edge clip

    assign pix_valid = busy && in_mask && in_screen && (credits != 3'd0);
    // Masked or clipped positions are skipped without a credit
    assign step      = pix_valid || (busy && !(in_mask && in_screen));
    assign row_last  = col_cnt == cur.w - 1'b1;
    assign last      = row_last && (row_cnt == cur.h - 1'b1);

    always_ff @(posedge clock_50) begin
        if (job_valid && job_ready)
            cur <= job;
    end

    always_ff @(posedge clock_50) begin
        if (rst) begin
            busy     <= 1'b0;
            job_done <= 1'b0;
            col_cnt  <= '0;
            row_cnt  <= '0;
        end else begin
            job_done <= step && last;
            if (job_valid && job_ready) begin
                busy    <= 1'b1;
                col_cnt <= '0;
                row_cnt <= '0;
            end else if (step) begin
                if (row_last) begin
                    col_cnt <= '0;
                    row_cnt <= row_cnt + 1'b1;
                    if (last)
                        busy <= 1'b0;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    // Credit counter, saturates at the reset value
    always_ff @(posedge clock_50) begin
        if (rst) begin
            credits <= 3'(`CREDIT_MAX);
        end else begin
            case ({pix_valid, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   if (credits < 3'(`CREDIT_MAX)) credits <= credits + 1'b1;
                default: credits <= credits;   // Spend and return cancel
            endcase
        end
    end

endmodule

// File: verilog/draw_sequencer.sv
`timescale 1ns/1ps
`include "runner_consts.svh"

module draw_sequencer (
    input  logic                    clock_50,
    input  logic                    rst,
    input  logic                    run,
    input  logic                    job_ready,
    input  logic                    job_done,
    input  runner_pkg::coord_t      obs_x,
    input  runner_pkg::coord_t      obs_y,
    input  runner_pkg::sprite_t     obs_sprite,
    input  runner_pkg::colour_t     obs_colour,
    input  logic                    obs_visible,
    output runner_pkg::raster_job_t job,
    output logic                    job_valid,
    output logic [3:0]              obs_index,
    output logic                    advance_scroll,
    output logic                    frame_done
);

    runner_pkg::seq_state_t state;
    logic                   issued;      // Job accepted, waiting for job_done
    logic [14:0]            frame_cnt;   // Cycles since last frame start
    logic                   frame_start;
    logic                   last_obs;
    logic                   want_job;

    assign frame_start = (state == runner_pkg::SEQ_IDLE) && run &&
                         (frame_cnt >= 15'(`FRAME_CYCLES));
    assign last_obs    = obs_index == 4'(`NUM_OBSTACLES - 1);
    assign want_job    = (state == runner_pkg::SEQ_CLEAR) || (state == runner_pkg::SEQ_PLAYER) ||
                         ((state == runner_pkg::SEQ_OBSTACLE) && obs_visible);
    assign job_valid      = want_job && !issued;
    assign frame_done     = state == runner_pkg::SEQ_DONE;
    assign advance_scroll = state == runner_pkg::SEQ_DONE;

    always_comb begin
        job          = '0;
        job.w        = runner_pkg::span_t'(`SPRITE_SIZE);
        job.h        = runner_pkg::span_t'(`SPRITE_SIZE);
        job.use_mask = 1'b1;
        case (state)
            runner_pkg::SEQ_CLEAR: begin
                job.w        = runner_pkg::span_t'(`SCREEN_W);
                job.h        = runner_pkg::span_t'(`SCREEN_H);
                job.colour   = `COL_BLACK;
                job.sprite   = `SPRITE_SQUARE;
                job.use_mask = 1'b0;
                job.plain    = 1'b1;   // Top row first
            end
            runner_pkg::SEQ_PLAYER: begin
                job.x      = runner_pkg::coord_t'(`PLAYER_X);
                job.y      = runner_pkg::coord_t'(`PLAYER_Y);
                job.colour = `COL_RED;
                job.sprite = `SPRITE_SQUARE;
            end
            default: begin
                job.x      = obs_x;
                job.y      = obs_y;
                job.colour = obs_colour;
                job.sprite = obs_sprite;
            end
        endcase
    end

    always_ff @(posedge clock_50) begin
        if (rst) begin
            state     <= runner_pkg::SEQ_IDLE;
            issued    <= 1'b0;
            obs_index <= '0;
            frame_cnt <= 15'(`FRAME_CYCLES);  // First frame may start at once
        end else begin
            if (frame_start)
                frame_cnt <= 15'd1;
            else if (frame_cnt < 15'(`FRAME_CYCLES))
                frame_cnt <= frame_cnt + 15'd1;

            if (job_valid && job_ready)
                issued <= 1'b1;
            else if (job_done)
                issued <= 1'b0;

            case (state)
                runner_pkg::SEQ_IDLE:   if (frame_start) state <= runner_pkg::SEQ_CLEAR;
                runner_pkg::SEQ_CLEAR:  if (job_done) state <= runner_pkg::SEQ_PLAYER;
                runner_pkg::SEQ_PLAYER: begin
                    if (job_done) begin
                        state     <= runner_pkg::SEQ_OBSTACLE;
                        obs_index <= '0;
                    end
                end
                runner_pkg::SEQ_OBSTACLE: begin
                    // Invisible entries are passed over with no job
                    if (job_done || (!obs_visible && !issued)) begin
                        if (last_obs)
                            state <= runner_pkg::SEQ_DONE;
                        else
                            obs_index <= obs_index + 1'b1;
                    end
                end
                default: state <= runner_pkg::SEQ_IDLE;  // Done lasts one cycle
            endcase
        end
    end

endmodule

// File: verilog/scene_renderer.sv
`timescale 1ns/1ps

module scene_renderer (
    input  logic               clock_50,
    input  logic               rst,
    input  logic               run,
    input  logic               credit_return,
    output runner_pkg::pixel_t pix,
    output logic               pix_valid,
    output logic               frame_done
);

    // Job handshake
    runner_pkg::raster_job_t job;
    logic                    job_valid;
    logic                    job_ready;
    logic                    job_done;

    // Level lookup
    logic [3:0]              obs_index;
    logic                    advance_scroll;
    runner_pkg::coord_t      obs_x;
    runner_pkg::coord_t      obs_y;
    runner_pkg::sprite_t     obs_sprite;
    runner_pkg::colour_t     obs_colour;
    logic                    obs_visible;

    // Sprite row limits
    runner_pkg::sprite_t     sprite;
    runner_pkg::row_t        row;
    runner_pkg::row_t        row_start;
    runner_pkg::row_t        row_end;

    draw_sequencer u_sequencer (
        .clock_50       (clock_50),
        .rst            (rst),
        .run            (run),
        .job_ready      (job_ready),
        .job_done       (job_done),
        .obs_x          (obs_x),
        .obs_y          (obs_y),
        .obs_sprite     (obs_sprite),
        .obs_colour     (obs_colour),
        .obs_visible    (obs_visible),
        .job            (job),
        .job_valid      (job_valid),
        .obs_index      (obs_index),
        .advance_scroll (advance_scroll),
        .frame_done     (frame_done)
    );

    obstacle_table u_obstacles (
        .clock_50       (clock_50),
        .rst            (rst),
        .advance_scroll (advance_scroll),
        .obs_index      (obs_index),
        .obs_x          (obs_x),
        .obs_y          (obs_y),
        .obs_sprite     (obs_sprite),
        .obs_colour     (obs_colour),
        .obs_visible    (obs_visible)
    );

    raster_engine u_raster (
        .clock_50      (clock_50),
        .rst           (rst),
        .job           (job),
        .job_valid     (job_valid),
        .credit_return (credit_return),
        .row_start     (row_start),
        .row_end       (row_end),
        .job_ready     (job_ready),
        .job_done      (job_done),
        .pix           (pix),
        .pix_valid     (pix_valid),
        .sprite        (sprite),
        .row           (row)
    );

    sprite_rom u_sprite_rom (
        .sprite    (sprite),
        .row       (row),
        .row_start (row_start),
        .row_end   (row_end)
    );

endmodule

// File: tests/tb_scene_renderer.sv
`timescale 1ns/1ps
`include "runner_consts.svh"

module tb_scene_renderer;

    typedef enum logic [1:0] {
        CREDIT_IMMEDIATE,
        CREDIT_RANDOM,
        CREDIT_PAUSE
    } credit_mode_t;

    // Frames to draw, sink behaviour and run level of one test step
    typedef struct packed {
        logic [3:0]   frames;
        credit_mode_t mode;
        logic         run;
    } step_t;

    localparam int NUM_STEPS = 4;

    logic               clock_50;
    logic               rst;
    logic               run;
    logic               credit_return;
    runner_pkg::pixel_t pix;
    logic               pix_valid;
    logic               frame_done;

    step_t              steps [NUM_STEPS];
    runner_pkg::pixel_t exp_q [$];   // Expected pixels of the current frame
    int                 due_q [$];   // Cycle at which each held credit goes back
    credit_mode_t       mode;
    integer             seed;
    int                 cycle;
    int                 received;
    int                 returned;
    int                 frame_idx;
    int                 pix_in_frame;
    int                 offset;      // Scroll offset of the frame being drawn
    int                 mismatches;
    int                 other_errors;

    scene_renderer u_dut (
        .clock_50      (clock_50),
        .rst           (rst),
        .run           (run),
        .credit_return (credit_return),
        .pix           (pix),
        .pix_valid     (pix_valid),
        .frame_done    (frame_done)
    );

    initial begin
        clock_50 = 1'b0;
        forever #4 clock_50 = ~clock_50;
    end

    function automatic step_t make_step(int frames, credit_mode_t m, logic r);
        step_t s;
        s.frames = 4'(frames);
        s.mode   = m;
        s.run    = r;
        return s;
    endfunction

    function automatic runner_pkg::pixel_t make_pixel(int x, int y, int colour);
        runner_pkg::pixel_t p;
        p.x      = runner_pkg::coord_t'(x);
        p.y      = runner_pkg::coord_t'(y);
        p.colour = runner_pkg::colour_t'(colour);
        return p;
    endfunction

    // World x of each level entry as 69 and then steps of 10 from 99
    function automatic int world_x(int i);
        return (i == 0) ? 69 : 89 + 10 * i;
    endfunction

    function automatic int level_y(int i);
        case (i % 5)
            0, 4:    return 89;
            1, 3:    return 59;
            default: return 39;
        endcase
    endfunction

    task automatic build_frame(int off);
        int x;
        int top;
        exp_q.delete();
        for (int yy = 0; yy < `SCREEN_H; yy++)
            for (int xx = 0; xx < `SCREEN_W; xx++)
                exp_q.push_back(make_pixel(xx, yy, `COL_BLACK));
        for (int r = 0; r < `SPRITE_SIZE; r++)
            for (int c = 0; c < `SPRITE_SIZE; c++)
                exp_q.push_back(make_pixel(`PLAYER_X + c, `PLAYER_Y - r, `COL_RED));
        for (int i = 0; i < `NUM_OBSTACLES; i++) begin
            x = world_x(i) - off;
            if (world_x(i) < off || x > `SCREEN_W - 1)
                continue;                          // Off screen so no job
            for (int r = 0; r < `SPRITE_SIZE; r++) begin
                top = `SPRITE_SIZE - 1 - r;        // Spike rows counted from the tip
                for (int c = 0; c < `SPRITE_SIZE; c++) begin
                    if (i >= 5 && (c < 4 - top / 2 || c > 5 + top / 2))
                        continue;
                    if (x + c >= `SCREEN_W)
                        continue;
                    exp_q.push_back(make_pixel(x + c, level_y(i) - r,
                                               (i < 5) ? `COL_YELLOW : `COL_WHITE));
                end
            end
        end
    endtask

    // One clock of the pixel sink on the falling edge
    task automatic service_cycle(bit idle);
        int                 delay;
        runner_pkg::pixel_t exp_pix;
        @(negedge clock_50);
        cycle++;
        if (idle && (pix_valid || frame_done)) begin
            $display("mismatch at %0t: pix_valid or frame_done high while no frame should run",
                     $time);
            other_errors++;
        end
        if (!idle && pix_valid) begin
            received++;
            if (exp_q.size() == 0) begin
                $display("mismatch at %0t: a pixel arrived after its frame was complete",
                         $time);
                other_errors++;
            end else begin
                exp_pix = exp_q.pop_front();
                if (pix !== exp_pix) begin
                    $display("mismatch at %0t: frame %0d pix %0d got %0d,%0d,%0d exp %0d,%0d,%0d",
                             $time, frame_idx, pix_in_frame, pix.x, pix.y, pix.colour,
                             exp_pix.x, exp_pix.y, exp_pix.colour);
                    mismatches++;
                end
            end
            pix_in_frame++;
            case (mode)
                CREDIT_RANDOM: delay = 1 + {$random(seed)} % 6;
                CREDIT_PAUSE:  delay = (received % 2000 == 1) ? 200 : 1;  // Long hold
                default:       delay = 1;
            endcase
            due_q.push_back(cycle + delay);
        end
        if (!idle && frame_done) begin
            if (exp_q.size() != 0) begin
                $display("mismatch at %0t: frame %0d ended with %0d pixels still missing",
                         $time, frame_idx, exp_q.size());
                other_errors++;
            end
            frame_idx++;
            offset = (offset + `SCROLL_STEP) % `WORLD_W;
            build_frame(offset);
            pix_in_frame = 0;
        end
        credit_return = 1'b0;
        if (due_q.size() != 0 && due_q[0] <= cycle) begin
            credit_return = 1'b1;
            void'(due_q.pop_front());
            returned++;
        end
        if (received - returned > `CREDIT_MAX) begin
            $display("mismatch at %0t: more pixels are outstanding than credits allow", $time);
            other_errors++;
        end
    endtask

    initial begin
        int seen;
        seed          = 46;
        cycle         = 0;
        received      = 0;
        returned      = 0;
        frame_idx     = 0;
        pix_in_frame  = 0;
        offset        = 0;
        mismatches    = 0;
        other_errors  = 0;
        mode          = CREDIT_IMMEDIATE;
        rst           = 1'b1;
        run           = 1'b0;
        credit_return = 1'b0;
        steps[0] = make_step(0, CREDIT_IMMEDIATE, 1'b0);  // Quiet check with run low
        steps[1] = make_step(2, CREDIT_IMMEDIATE, 1'b1);
        steps[2] = make_step(1, CREDIT_RANDOM, 1'b1);
        steps[3] = make_step(1, CREDIT_PAUSE, 1'b1);
        build_frame(0);
        repeat (4) @(posedge clock_50);
        @(negedge clock_50);
        rst = 1'b0;
        for (int s = 0; s < NUM_STEPS; s++) begin
            mode = steps[s].mode;
            run  = steps[s].run;
            if (steps[s].frames == 0) begin
                repeat (100) service_cycle(1'b1);
            end else begin
                seen = 0;
                while (seen < steps[s].frames) begin
                    service_cycle(1'b0);
                    if (frame_done)
                        seen++;
                end
            end
            run = 1'b0;   // Run stays low after the last step
        end
        repeat (200) service_cycle(1'b1);
        $display("Errors: %0d pixel mismatches, %0d other", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // Watchdog sized from the frames in the step table
    initial begin
        int limit;
        @(negedge rst);
        limit = 0;
        for (int s = 0; s < NUM_STEPS; s++)
            limit += steps[s].frames * (`FRAME_CYCLES + 40000);
        repeat (limit) @(posedge clock_50);
        $display("Timeout after %0d cycles, the frames did not complete", limit);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: build.f
+incdir+include
verilog/runner_pkg.sv
verilog/sprite_rom.sv
verilog/obstacle_table.sv
verilog/raster_engine.sv
verilog/draw_sequencer.sv
verilog/scene_renderer.sv
tests/tb_scene_renderer.sv
